//--- files.f
verilog/dbg_bus_pkg.sv
verilog/cpu_ctrl_pkg.sv
verilog/dbg_cmd_if.sv
verilog/dbg_skid_buffer.sv
verilog/dbg_write_path.sv
verilog/dbg_read_path.sv
verilog/cpu_run_control.sv
verilog/zip_dbg_top.sv
verif/dbg_checker.sv
verif/tb_zip_dbg.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tb_zip_dbg -o sim_zip_dbg > build.log 2>&1 &&
./obj_dir/sim_zip_dbg > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -qx "TESTS PASSED" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

//--- verif/dbg_checker.sv
// Debug front end checker
module dbg_checker (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	// Bus responses
	input  logic i_bvalid,
	input  logic i_bready,
	input  logic i_rvalid,
	input  logic i_rready,
	input  logic [31:0] i_rdata,
	// Core ports
	input  logic i_cpu_dbg_we,
	input  logic i_cpu_dbg_stall,
	input  logic [4:0] i_cpu_dbg_wreg,
	input  logic [31:0] i_cpu_dbg_wdata,
	input  logic i_cpu_reset,
	input  logic i_cpu_halt,
	input  logic i_cpu_clear_cache,
	// Current test from the stimulus driver
	input  logic i_test_active,
	input  logic [3:0] i_test_op,
	input  logic [7:0] i_test_addr,
	input  logic [3:0] i_test_strb,
	input  logic [31:0] i_test_data,
	input  logic [31:0] i_test_expect,
	input  logic i_report,
	output int o_pass_cnt,
	output int o_fail_cnt
);
	timeunit 1ns;
	timeprecision 100ps;

	int test_num = 0;
	int b_cnt = 0;
	int r_cnt = 0;
	int cw_cnt = 0;
	int hold_cnt = 0;
	logic [31:0] last_rdata = '0;
	logic [31:0] last_wdata = '0;
	logic [4:0] last_wreg = '0;
	logic cc_seen = 1'b0;
	logic rst_seen = 1'b0;
	logic prev_reset = 1'b0;
	logic was_active = 1'b0;
	logic reset_done = 1'b0;
	logic ok = 1'b1;

	initial
	begin
		o_pass_cnt = 0;
		o_fail_cnt = 0;
	end

	task automatic report_error(input string msg);
		$display("Error at %0t: test %0d %s", $time, test_num, msg);
		ok = 1'b0;
	endtask

	////////////////////////////////////////
	// End of test comparison
	////////////////////////////////////////
	task automatic check_test();
		logic reg_wr;
		logic [31:0] got;
		reg_wr = !i_test_addr[7] && (|i_test_strb);
		got = last_rdata & i_test_data;
		ok = 1'b1;
		case (i_test_op)
			4'h0, 4'h3:
			begin
				if (b_cnt != 1)
					report_error($sformatf("saw %0d write responses, expected 1", b_cnt));
				if (r_cnt != 0)
					report_error("read response during a write");
				// Core register writes reach the core exactly once
				if (reg_wr && (cw_cnt != 1 || last_wreg != i_test_addr[6:2]
					|| last_wdata != i_test_data))
					report_error($sformatf("core write r%0d=%h count %0d, expected r%0d=%h",
						last_wreg, last_wdata, cw_cnt, i_test_addr[6:2], i_test_data));
				if (!reg_wr && cw_cnt != 0)
					report_error("unexpected core register write");
				if (i_test_op == 4'h3 && !cc_seen)
					report_error("no clear cache pulse");
			end
			4'h1:
			begin
				if (r_cnt != 1 || b_cnt != 0)
					report_error($sformatf("saw %0d read, %0d write responses", r_cnt, b_cnt));
				if (got != i_test_expect)
					report_error($sformatf("read %h masked %h, expected %h",
						last_rdata, got, i_test_expect));
			end
			4'h2:
				if (i_cpu_halt != i_test_expect[0])
					report_error($sformatf("halt is %0b, expected %0b",
						i_cpu_halt, i_test_expect[0]));
			4'h4:
				if (!rst_seen || i_cpu_reset)
					report_error("break did not pulse core reset");
			4'h5:
				if (hold_cnt != int'(i_test_expect))
					report_error($sformatf("reset held %0d cycles, expected %0d",
						hold_cnt, i_test_expect));
			default:
				report_error($sformatf("unknown operation %0h", i_test_op));
		endcase
		if (ok)
		begin
			o_pass_cnt++;
			$display("Test %0d op %0h passed", test_num, i_test_op);
		end
		else
		begin
			o_fail_cnt++;
			$display("Test %0d op %0h failed", test_num, i_test_op);
		end
	endtask

	////////////////////////////////////////
	// Bus and core monitor
	////////////////////////////////////////
	always @(posedge S_AXI_ACLK)
	begin
		// New test, clear the event counts
		if (i_test_active && !was_active)
		begin
			test_num++;
			b_cnt = 0;
			r_cnt = 0;
			cw_cnt = 0;
			cc_seen = 1'b0;
			rst_seen = 1'b0;
		end
		if (i_test_active)
		begin
			if (i_bvalid && i_bready)
				b_cnt++;
			if (i_rvalid && i_rready)
			begin
				r_cnt++;
				last_rdata = i_rdata;
			end
			// Core takes a write when not stalled
			if (i_cpu_dbg_we && !i_cpu_dbg_stall)
			begin
				cw_cnt++;
				last_wreg = i_cpu_dbg_wreg;
				last_wdata = i_cpu_dbg_wdata;
			end
			if (i_cpu_clear_cache)
				cc_seen = 1'b1;
			if (i_cpu_reset && !prev_reset)
				rst_seen = 1'b1;
		end
		if (!i_test_active && was_active)
			check_test();
		// Reset hold length after bus reset
		if (S_AXI_ARESETN && !reset_done)
		begin
			if (i_cpu_reset)
				hold_cnt++;
			else
				reset_done = 1'b1;
		end
		prev_reset = i_cpu_reset;
		was_active = i_test_active;
		if (i_report)
			$display("Summary: %0d tests, %0d passed, %0d failed",
				test_num, o_pass_cnt, o_fail_cnt);
	end

endmodule

//--- verif/dbg_testdata.txt
// One hex word per test: op(1) addr(2) strb(1) data(8) expect(8)
// op 0 write, 1 read (data is mask), 2 wait halt, 3 clear cache, 4 break, 5 reset hold
5000000000000000000A
1800FFFFFDFF00005000
00CF1234567800000000
10C0FFFFFFFF12345678
1800FFFFFDFF00005400
1140FFFFFFFFA0000505
080F0000000000000000
20000000000000000000
1800FFFFFDFF00005000
080F0000040000000000
20000000000000000001
1800FFFFFDFF00005400
07CFDEADBEEF00000000
000FA5A50F0F00000000
17C0FFFFFFFFDEADBEEF
1000FFFFFFFFA5A50F0F
080F0000050000000000
20000000000000000001
1800FFFFFDFF00005400
380F00000C0000000000
1800FFFFFDFF00005400
080F0000000000000000
20000000000000000000
40000000000000000000
1800FFFFFDFF00005000
10C0FFFFFFFF12345678
00800000000000000000
1800FFFFFDFF00005000

//--- verif/tb_zip_dbg.sv
// Debug front end testbench
module tb_zip_dbg;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_DURATION = 10;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_TESTS = 64;
	localparam int CYCLES_PER_TEST = 200;
	// Longest wait for a halt change before the checker compares
	localparam int HALT_WAIT_CYCLES = 64;

	logic clk;
	logic rstn;
	logic awvalid;
	logic awready;
	logic [7:0] awaddr;
	logic wvalid;
	logic wready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic bvalid;
	logic bready = 1'b0;
	logic arvalid;
	logic arready;
	logic [7:0] araddr;
	logic rvalid;
	logic rready = 1'b0;
	logic [31:0] rdata;
	logic cpu_stall = 1'b0;
	logic [31:0] cpu_data;
	logic [2:0] cpu_cc;
	logic cpu_break;
	logic interrupt;
	logic cpu_reset;
	logic cpu_halt;
	logic cpu_clear_cache;
	logic cpu_we;
	logic [4:0] cpu_wreg;
	logic [31:0] cpu_wdata;
	logic [4:0] cpu_rreg;

	// Packed test line of op, addr, strb, data and expect
	logic [79:0] tests [0:MAX_TESTS-1];
	logic [31:0] core_regs [0:31];
	logic [15:0] lfsr = 16'd67;
	int num_tests;
	int limit = 1000000;
	int cycles = 0;
	int idx;
	int pass_cnt;
	int fail_cnt;
	logic t_active;
	logic [3:0] t_op;
	logic [7:0] t_addr;
	logic [3:0] t_strb;
	logic [31:0] t_data;
	logic [31:0] t_expect;
	logic report;

	zip_dbg_top #(
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(1'b0)
	) i_dut (
		.S_AXI_ACLK(clk), .S_AXI_ARESETN(rstn),
		.S_DBG_AWVALID(awvalid), .S_DBG_AWREADY(awready), .S_DBG_AWADDR(awaddr),
		.S_DBG_WVALID(wvalid), .S_DBG_WREADY(wready), .S_DBG_WDATA(wdata),
		.S_DBG_WSTRB(wstrb), .S_DBG_BVALID(bvalid), .S_DBG_BREADY(bready),
		.S_DBG_ARVALID(arvalid), .S_DBG_ARREADY(arready), .S_DBG_ARADDR(araddr),
		.S_DBG_RVALID(rvalid), .S_DBG_RREADY(rready), .S_DBG_RDATA(rdata),
		.i_cpu_dbg_stall(cpu_stall), .i_cpu_dbg_data(cpu_data), .i_cpu_dbg_cc(cpu_cc),
		.i_cpu_break(cpu_break), .i_interrupt(interrupt),
		.o_cpu_reset(cpu_reset), .o_cpu_halt(cpu_halt),
		.o_cpu_clear_cache(cpu_clear_cache), .o_cpu_dbg_we(cpu_we),
		.o_cpu_dbg_wreg(cpu_wreg), .o_cpu_dbg_wdata(cpu_wdata), .o_cpu_dbg_rreg(cpu_rreg)
	);

	dbg_checker u_checker (
		.S_AXI_ACLK(clk), .S_AXI_ARESETN(rstn),
		.i_bvalid(bvalid), .i_bready(bready), .i_rvalid(rvalid), .i_rready(rready),
		.i_rdata(rdata), .i_cpu_dbg_we(cpu_we), .i_cpu_dbg_stall(cpu_stall),
		.i_cpu_dbg_wreg(cpu_wreg), .i_cpu_dbg_wdata(cpu_wdata), .i_cpu_reset(cpu_reset),
		.i_cpu_halt(cpu_halt), .i_cpu_clear_cache(cpu_clear_cache),
		.i_test_active(t_active), .i_test_op(t_op), .i_test_addr(t_addr),
		.i_test_strb(t_strb), .i_test_data(t_data), .i_test_expect(t_expect),
		.i_report(report), .o_pass_cnt(pass_cnt), .o_fail_cnt(fail_cnt)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Galois LFSR stepped once per random bit
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	////////////////////////////////////////
	// Core model
	////////////////////////////////////////
	assign cpu_data = core_regs[cpu_rreg];

	always @(posedge clk)
	begin
		if (!rstn)
			for (int i = 0; i < 32; i++)
				core_regs[i] <= 32'hA000_0000 | (32'(i) << 8) | 32'(i);
		else if (cpu_we && !cpu_stall)
			core_regs[cpu_wreg] <= cpu_wdata;
	end

	// Random stall and response back-pressure
	// Halted core never stalls
	always @(negedge clk)
	begin
		lfsr = lfsr_next(lfsr);
		cpu_stall = cpu_halt ? 1'b0 : lfsr[0];
		lfsr = lfsr_next(lfsr);
		bready = lfsr[0];
		lfsr = lfsr_next(lfsr);
		rready = lfsr[0];
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > limit)
		begin
			$display("Timeout after %0d cycles, a handshake or wait never finished", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// Bus transactions
	////////////////////////////////////////
	task automatic write_word();
		logic aw_done;
		logic w_done;
		logic b_done;
		awvalid = 1'b1;
		awaddr = t_addr;
		wvalid = 1'b1;
		wdata = t_data;
		wstrb = t_strb;
		aw_done = 1'b0;
		w_done = 1'b0;
		b_done = 1'b0;
		while (!(aw_done && w_done))
		begin
			@(posedge clk);
			if (awvalid && awready)
				aw_done = 1'b1;
			if (wvalid && wready)
				w_done = 1'b1;
			@(negedge clk);
			if (aw_done)
				awvalid = 1'b0;
			if (w_done)
				wvalid = 1'b0;
		end
		while (!b_done)
		begin
			@(posedge clk);
			b_done = bvalid && bready;
			@(negedge clk);
		end
		// Let the core take any held register write
		while (cpu_we)
			@(negedge clk);
	endtask

	task automatic read_word();
		logic ar_done;
		logic r_done;
		arvalid = 1'b1;
		araddr = t_addr;
		ar_done = 1'b0;
		r_done = 1'b0;
		while (!ar_done)
		begin
			@(posedge clk);
			ar_done = arvalid && arready;
			@(negedge clk);
		end
		arvalid = 1'b0;
		while (!r_done)
		begin
			@(posedge clk);
			r_done = rvalid && rready;
			@(negedge clk);
		end
	endtask

	task automatic run_test(input logic [79:0] t);
		int waited;
		@(negedge clk);
		t_op = t[79:76];
		t_addr = t[75:68];
		t_strb = t[67:64];
		t_data = t[63:32];
		t_expect = t[31:0];
		t_active = 1'b1;
		case (t_op)
			4'h0: write_word();
			4'h1: read_word();
			4'h2:
			begin
				// Bounded wait, the checker compares the halt level afterwards
				waited = 0;
				@(negedge clk);
				while (cpu_halt != t_expect[0] && waited < HALT_WAIT_CYCLES)
				begin
					@(negedge clk);
					waited++;
				end
			end
			4'h3:
			begin
				write_word();
				while (cpu_clear_cache)
					@(negedge clk);
			end
			4'h4:
			begin
				cpu_break = 1'b1;
				@(negedge clk);
				cpu_break = 1'b0;
				while (cpu_reset)
					@(negedge clk);
			end
			default:
			begin
				@(negedge clk);
				while (cpu_reset)
					@(negedge clk);
			end
		endcase
		t_active = 1'b0;
	endtask

	////////////////////////////////////////
	// Stimulus driver
	////////////////////////////////////////
	initial
	begin
		rstn = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		arvalid = 1'b0;
		araddr = '0;
		cpu_cc = 3'b101;
		cpu_break = 1'b0;
		interrupt = 1'b0;
		t_active = 1'b0;
		t_op = '0;
		t_addr = '0;
		t_strb = '0;
		t_data = '0;
		t_expect = '0;
		report = 1'b0;
		// Unused entries end the list
		for (idx = 0; idx < MAX_TESTS; idx++)
			tests[idx] = '1;
		$readmemh("verif/dbg_testdata.txt", tests);
		num_tests = 0;
		while (num_tests < MAX_TESTS && tests[num_tests][79:76] != 4'hF)
			num_tests++;
		limit = CYCLES_PER_TEST * num_tests + RESET_CYCLES;
		repeat (RESET_CYCLES) @(negedge clk);
		rstn = 1'b1;
		for (idx = 0; idx < num_tests; idx++)
			run_test(tests[idx]);
		repeat (2) @(negedge clk);
		report = 1'b1;
		@(negedge clk);
		report = 1'b0;
		if (fail_cnt == 0 && pass_cnt == num_tests && num_tests > 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- verilog/cpu_ctrl_pkg.sv
// Core control package
// Command bits, status layout, core-side types
package cpu_ctrl_pkg;

	////////////////////////////////////////
	// Core-side types
	////////////////////////////////////////
	localparam int REG_IDX_W = 5;
	localparam int CC_W = 3;

	// One of the 32 core registers
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	// Condition code from the core
	typedef logic [CC_W-1:0] cpu_cc_t;

	////////////////////////////////////////
	// Command bits
	////////////////////////////////////////
	// Same positions in the control write and the status word
	localparam int RESET_BIT = 6;
	localparam int STEP_BIT = 8;
	localparam int HALT_BIT = 10;
	localparam int CLEAR_CACHE_BIT = 11;

	// Status only fields
	localparam int STATUS_INT_BIT = 7;
	// High while the core is not stalled
	localparam int STATUS_RUN_BIT = 9;
	localparam int STATUS_CC_LSB = 12;
	localparam int STATUS_BREAK_BIT = 15;

endpackage

//--- verilog/cpu_run_control.sv
// Run control
// Reset hold, halt, step, clear cache, status word
module cpu_run_control #(
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED = 1'b0
) (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	dbg_cmd_if.ctrl_side cmd,
	input  logic i_cpu_dbg_stall,
	input  logic i_cpu_break,
	input  cpu_ctrl_pkg::cpu_cc_t i_cpu_dbg_cc,
	input  logic i_interrupt,
	output logic o_cpu_reset,
	output logic o_cpu_halt,
	output logic o_cpu_clear_cache,
	output dbg_bus_pkg::dbg_word_t o_status
);

	localparam int CW = (RESET_DURATION > 0) ? $clog2(RESET_DURATION + 1) : 1;

	typedef enum logic [1:0] {
		HOLD_RESET,
		RUN,
		STEPPING,
		HALTED
	} run_state_t;

	run_state_t state;
	run_state_t state_next;
	logic [CW-1:0] rst_cnt;
	logic cc_flag;
	logic hi_wr;
	logic reset_wr;
	logic halt_wr;
	logic step_wr;
	logic cc_wr;
	logic hold_req;
	logic halt_set;
	logic release_ok;

	////////////////////////////////////////
	// Command decode
	////////////////////////////////////////
	// Reset bit in lane 0, the rest in lane 1
	assign reset_wr = cmd.cmd_write && cmd.cmd_strb[cpu_ctrl_pkg::RESET_BIT / 8]
		&& cmd.cmd_data[cpu_ctrl_pkg::RESET_BIT];
	assign hi_wr = cmd.cmd_write && cmd.cmd_strb[cpu_ctrl_pkg::HALT_BIT / 8];
	assign halt_wr = hi_wr && cmd.cmd_data[cpu_ctrl_pkg::HALT_BIT];
	assign step_wr = hi_wr && cmd.cmd_data[cpu_ctrl_pkg::STEP_BIT];
	// Cache flush only when asked together with halt
	assign cc_wr = halt_wr && cmd.cmd_data[cpu_ctrl_pkg::CLEAR_CACHE_BIT];

	// Startup hold, explicit reset, or break when free running
	assign hold_req = (rst_cnt > CW'(1)) || reset_wr || (i_cpu_break && !START_HALTED);

	// Any of these forces a halt
	assign halt_set = (halt_wr && !step_wr)
		|| cmd.reg_write
		|| (state == STEPPING && !i_cpu_dbg_stall)
		|| cc_flag
		|| (hi_wr && cmd.cmd_data[cpu_ctrl_pkg::CLEAR_CACHE_BIT])
		|| (i_cpu_break && START_HALTED);

	// Run or step request, only once the core is idle
	assign release_ok = hi_wr && (!cmd.cmd_data[cpu_ctrl_pkg::HALT_BIT] || step_wr)
		&& !cmd.reg_pending && !i_cpu_dbg_stall;

	////////////////////////////////////////
	// Reset hold counter
	////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rst_cnt <= CW'(RESET_DURATION);
		else if (rst_cnt != '0)
			rst_cnt <= rst_cnt - 1'b1;
	end

	////////////////////////////////////////
	// Run state FSM
	////////////////////////////////////////
	always_comb
	begin
		state_next = state;
		if (hold_req)
			state_next = HOLD_RESET;
		else if (halt_set)
			state_next = HALTED;
		else if (state == HOLD_RESET)
			state_next = START_HALTED ? HALTED : RUN;
		else if (release_ok)
			state_next = step_wr ? STEPPING : RUN;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			state <= HOLD_RESET;
		else
			state <= state_next;
	end

	// Flush request sits beside the state
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || hold_req)
			cc_flag <= 1'b0;
		else if (cc_wr)
			cc_flag <= 1'b1;
		else if (o_cpu_halt && !i_cpu_dbg_stall)
			cc_flag <= 1'b0;
	end

	assign o_cpu_reset = (state == HOLD_RESET);
	assign o_cpu_halt = (state == HALTED) || (state == HOLD_RESET && START_HALTED);
	assign o_cpu_clear_cache = cc_flag;

	// Status word, unused bits zero
	always_comb
	begin
		o_status = '0;
		o_status[cpu_ctrl_pkg::RESET_BIT] = o_cpu_reset;
		o_status[cpu_ctrl_pkg::STATUS_INT_BIT] = i_interrupt;
		o_status[cpu_ctrl_pkg::STEP_BIT] = (state == STEPPING);
		o_status[cpu_ctrl_pkg::STATUS_RUN_BIT] = !i_cpu_dbg_stall;
		o_status[cpu_ctrl_pkg::HALT_BIT] = o_cpu_halt;
		o_status[cpu_ctrl_pkg::CLEAR_CACHE_BIT] = cc_flag;
		o_status[cpu_ctrl_pkg::STATUS_CC_LSB +: cpu_ctrl_pkg::CC_W] = i_cpu_dbg_cc;
		o_status[cpu_ctrl_pkg::STATUS_BREAK_BIT] = i_cpu_break;
	end

	// Cache flush only ever seen by a halted core
	a_flush_halted: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_cpu_clear_cache |-> o_cpu_halt)
		else $error("clear cache raised while core runs");

endmodule

//--- verilog/dbg_bus_pkg.sv
// Debug bus package
// AXI-lite field widths and address decode
package dbg_bus_pkg;

	////////////////////////////////////////
	// Bus field widths
	////////////////////////////////////////
	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// Word index drops the byte offset
	localparam int WIDX_LSB = 2;
	localparam int WIDX_W = ADDR_W - WIDX_LSB;

	// Byte address as seen on AWADDR/ARADDR
	typedef logic [ADDR_W-1:0] dbg_addr_t;
	// Data word on WDATA/RDATA
	typedef logic [DATA_W-1:0] dbg_word_t;
	// One strobe per byte lane
	typedef logic [STRB_W-1:0] dbg_strb_t;
	// Address with the low two bits removed
	typedef logic [WIDX_W-1:0] dbg_widx_t;

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////
	// Set: control/status word, clear: index bits 4:0 name a core register
	localparam int CTRL_SEL_BIT = 5;

endpackage

//--- verilog/dbg_cmd_if.sv
// Debug command interface
// Accepted bus writes from the write path to run control
interface dbg_cmd_if;

	// Control word write accepted this cycle
	logic cmd_write;
	// Strobe and data of that write
	dbg_bus_pkg::dbg_strb_t cmd_strb;
	dbg_bus_pkg::dbg_word_t cmd_data;
	// Core register write with nonzero strobe accepted this cycle
	logic reg_write;
	// Core register write still waiting on the core
	logic reg_pending;

	// Write path drives everything
	modport write_side (
		output cmd_write, cmd_strb, cmd_data, reg_write, reg_pending
	);

	// Run control only listens
	modport ctrl_side (
		input cmd_write, cmd_strb, cmd_data, reg_write, reg_pending
	);

endinterface

//--- verilog/dbg_read_path.sv
// Debug read path
// Status and core register reads
module dbg_read_path (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	// AR channel
	input  logic i_arvalid,
	output logic o_arready,
	input  dbg_bus_pkg::dbg_addr_t i_araddr,
	// R channel
	output logic o_rvalid,
	input  logic i_rready,
	output dbg_bus_pkg::dbg_word_t o_rdata,
	// Status word from run control
	input  dbg_bus_pkg::dbg_word_t i_status,
	// Core register read port
	output cpu_ctrl_pkg::reg_idx_t o_cpu_dbg_rreg,
	input  dbg_bus_pkg::dbg_word_t i_cpu_dbg_data
);

	dbg_bus_pkg::dbg_widx_t ar_idx;
	dbg_bus_pkg::dbg_word_t cap_data;
	logic ar_valid;
	logic read_ready;
	logic ctrl_sel;
	logic cap_valid;

	dbg_skid_buffer #(
		.DW($bits(dbg_bus_pkg::dbg_widx_t))
	) u_ar_skid (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_arvalid),
		.o_ready(o_arready),
		.i_data(i_araddr[dbg_bus_pkg::ADDR_W-1:dbg_bus_pkg::WIDX_LSB]),
		.o_valid(ar_valid),
		.i_ready(read_ready),
		.o_data(ar_idx)
	);

	assign ctrl_sel = ar_idx[dbg_bus_pkg::CTRL_SEL_BIT];

	// One read in flight, R slot free or emptying
	assign read_ready = ar_valid && !cap_valid && (!o_rvalid || i_rready);

	// Core answers in the same cycle
	assign o_cpu_dbg_rreg = ar_idx[cpu_ctrl_pkg::REG_IDX_W-1:0];

	////////////////////////////////////////
	// Register capture stage
	////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			cap_valid <= 1'b0;
		else
			cap_valid <= read_ready && !ctrl_sel;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (read_ready)
			cap_data <= i_cpu_dbg_data;
	end

	////////////////////////////////////////
	// Read response
	////////////////////////////////////////
	// Status one cycle after accept, register two
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (!o_rvalid || i_rready)
			o_rvalid <= (read_ready && ctrl_sel) || cap_valid;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_rvalid || i_rready)
			o_rdata <= cap_valid ? cap_data : i_status;
	end

	a_one_in_flight: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(cap_valid && o_rvalid))
		else $error("capture stage overlaps RVALID");

endmodule

//--- verilog/dbg_skid_buffer.sv
// Skid buffer
// Two entries, registered upstream ready
module dbg_skid_buffer #(
	parameter int DW = 8
) (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	// Upstream side
	input  logic i_valid,
	output logic o_ready,
	input  logic [DW-1:0] i_data,
	// Downstream side
	output logic o_valid,
	input  logic i_ready,
	output logic [DW-1:0] o_data
);

	// Held item when downstream stalls
	logic r_valid;
	logic [DW-1:0] r_data;

	// Item moves in but not out
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Payload only, loads whenever the slot is free
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	// Ready is purely a register decode
	assign o_ready = !r_valid;

	// Empty buffer passes straight through
	assign o_valid = i_valid || r_valid;
	assign o_data = r_valid ? r_data : i_data;

	// Stalled output keeps both valid and payload
	a_hold_stalled: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_valid && !i_ready |=> o_valid && $stable(o_data))
		else $error("skid buffer dropped a stalled item");

endmodule

//--- verilog/dbg_write_path.sv
// Debug write path
// AW/W join, core register writes, B responses
module dbg_write_path (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	// AW channel
	input  logic i_awvalid,
	output logic o_awready,
	input  dbg_bus_pkg::dbg_addr_t i_awaddr,
	// W channel
	input  logic i_wvalid,
	output logic o_wready,
	input  dbg_bus_pkg::dbg_word_t i_wdata,
	input  dbg_bus_pkg::dbg_strb_t i_wstrb,
	// B channel
	output logic o_bvalid,
	input  logic i_bready,
	// Core register write port
	input  logic i_cpu_dbg_stall,
	output logic o_cpu_dbg_we,
	output cpu_ctrl_pkg::reg_idx_t o_cpu_dbg_wreg,
	output dbg_bus_pkg::dbg_word_t o_cpu_dbg_wdata,
	// To run control
	dbg_cmd_if.write_side cmd
);

	localparam int IDX_W = $bits(dbg_bus_pkg::dbg_widx_t);
	localparam int W_DW = $bits(dbg_bus_pkg::dbg_word_t) + $bits(dbg_bus_pkg::dbg_strb_t);

	dbg_bus_pkg::dbg_widx_t aw_idx;
	dbg_bus_pkg::dbg_word_t w_data;
	dbg_bus_pkg::dbg_strb_t w_strb;
	logic [W_DW-1:0] w_pack;
	logic aw_valid;
	logic w_valid;
	logic write_ready;
	logic ctrl_sel;
	logic has_strb;
	logic core_free;

	////////////////////////////////////////
	// Channel buffers
	////////////////////////////////////////
	dbg_skid_buffer #(
		.DW(IDX_W)
	) u_aw_skid (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_awvalid),
		.o_ready(o_awready),
		.i_data(i_awaddr[dbg_bus_pkg::ADDR_W-1:dbg_bus_pkg::WIDX_LSB]),
		.o_valid(aw_valid),
		.i_ready(write_ready),
		.o_data(aw_idx)
	);

	// Data and strobe travel together
	dbg_skid_buffer #(
		.DW(W_DW)
	) u_w_skid (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_wvalid),
		.o_ready(o_wready),
		.i_data({i_wdata, i_wstrb}),
		.o_valid(w_valid),
		.i_ready(write_ready),
		.o_data(w_pack)
	);

	assign w_data = w_pack[W_DW-1:$bits(dbg_bus_pkg::dbg_strb_t)];
	assign w_strb = w_pack[$bits(dbg_bus_pkg::dbg_strb_t)-1:0];

	////////////////////////////////////////
	// Accept decision
	////////////////////////////////////////
	assign ctrl_sel = aw_idx[dbg_bus_pkg::CTRL_SEL_BIT];
	assign has_strb = |w_strb;
	// Pending write slot is empty or completing
	assign core_free = !o_cpu_dbg_we || !i_cpu_dbg_stall;

	// Both halves present, B slot free, core slot free for register writes
	assign write_ready = aw_valid && w_valid
		&& (ctrl_sel || !has_strb || core_free)
		&& (!o_bvalid || i_bready);

	////////////////////////////////////////
	// Core register write
	////////////////////////////////////////
	// Held until the core takes it
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_cpu_dbg_we <= 1'b0;
		else if (core_free)
			o_cpu_dbg_we <= write_ready && has_strb && !ctrl_sel;
	end

	// Register number and value follow the strobe
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (core_free)
		begin
			o_cpu_dbg_wreg <= aw_idx[cpu_ctrl_pkg::REG_IDX_W-1:0];
			o_cpu_dbg_wdata <= w_data;
		end
	end

	// Write response, always OKAY
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (write_ready)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

	// Run control sees control writes in the accept cycle
	assign cmd.cmd_write = write_ready && ctrl_sel;
	assign cmd.cmd_strb = w_strb;
	assign cmd.cmd_data = w_data;
	assign cmd.reg_write = write_ready && !ctrl_sel && has_strb;
	assign cmd.reg_pending = o_cpu_dbg_we;

	a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_bvalid && !i_bready |=> o_bvalid)
		else $error("BVALID dropped before BREADY");

endmodule

//--- verilog/zip_dbg_top.sv
// Debug front end top level
module zip_dbg_top #(
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED = 1'b0
) (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	// AW channel
	input  logic S_DBG_AWVALID,
	output logic S_DBG_AWREADY,
	input  dbg_bus_pkg::dbg_addr_t S_DBG_AWADDR,
	// W channel
	input  logic S_DBG_WVALID,
	output logic S_DBG_WREADY,
	input  dbg_bus_pkg::dbg_word_t S_DBG_WDATA,
	input  dbg_bus_pkg::dbg_strb_t S_DBG_WSTRB,
	// B channel
	output logic S_DBG_BVALID,
	input  logic S_DBG_BREADY,
	// AR channel
	input  logic S_DBG_ARVALID,
	output logic S_DBG_ARREADY,
	input  dbg_bus_pkg::dbg_addr_t S_DBG_ARADDR,
	// R channel
	output logic S_DBG_RVALID,
	input  logic S_DBG_RREADY,
	output dbg_bus_pkg::dbg_word_t S_DBG_RDATA,
	// Core inputs
	input  logic i_cpu_dbg_stall,
	input  dbg_bus_pkg::dbg_word_t i_cpu_dbg_data,
	input  cpu_ctrl_pkg::cpu_cc_t i_cpu_dbg_cc,
	input  logic i_cpu_break,
	input  logic i_interrupt,
	// Core outputs
	output logic o_cpu_reset,
	output logic o_cpu_halt,
	output logic o_cpu_clear_cache,
	output logic o_cpu_dbg_we,
	output cpu_ctrl_pkg::reg_idx_t o_cpu_dbg_wreg,
	output dbg_bus_pkg::dbg_word_t o_cpu_dbg_wdata,
	output cpu_ctrl_pkg::reg_idx_t o_cpu_dbg_rreg
);

	dbg_bus_pkg::dbg_word_t status;

	dbg_cmd_if u_cmd ();

	////////////////////////////////////////
	// Bus side
	////////////////////////////////////////
	dbg_write_path u_write (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awvalid(S_DBG_AWVALID),
		.o_awready(S_DBG_AWREADY),
		.i_awaddr(S_DBG_AWADDR),
		.i_wvalid(S_DBG_WVALID),
		.o_wready(S_DBG_WREADY),
		.i_wdata(S_DBG_WDATA),
		.i_wstrb(S_DBG_WSTRB),
		.o_bvalid(S_DBG_BVALID),
		.i_bready(S_DBG_BREADY),
		.i_cpu_dbg_stall(i_cpu_dbg_stall),
		.o_cpu_dbg_we(o_cpu_dbg_we),
		.o_cpu_dbg_wreg(o_cpu_dbg_wreg),
		.o_cpu_dbg_wdata(o_cpu_dbg_wdata),
		.cmd(u_cmd.write_side)
	);

	dbg_read_path u_read (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_arvalid(S_DBG_ARVALID),
		.o_arready(S_DBG_ARREADY),
		.i_araddr(S_DBG_ARADDR),
		.o_rvalid(S_DBG_RVALID),
		.i_rready(S_DBG_RREADY),
		.o_rdata(S_DBG_RDATA),
		.i_status(status),
		.o_cpu_dbg_rreg(o_cpu_dbg_rreg),
		.i_cpu_dbg_data(i_cpu_dbg_data)
	);

	////////////////////////////////////////
	// Core control
	////////////////////////////////////////
	cpu_run_control #(
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(START_HALTED)
	) u_run (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.cmd(u_cmd.ctrl_side),
		.i_cpu_dbg_stall(i_cpu_dbg_stall),
		.i_cpu_break(i_cpu_break),
		.i_cpu_dbg_cc(i_cpu_dbg_cc),
		.i_interrupt(i_interrupt),
		.o_cpu_reset(o_cpu_reset),
		.o_cpu_halt(o_cpu_halt),
		.o_cpu_clear_cache(o_cpu_clear_cache),
		.o_status(status)
	);

endmodule
